//--- common/aes_ctr_pkg.sv
/*
 * AES CTR counter package
 * Default counter and slice widths, and the sparse state encoding
 * of the slice-serial increment FSM
 */
package aes_ctr_pkg;

  ////////////////////
  // Default widths
  ////////////////////

  // Full counter block as used by CTR mode
  parameter int unsigned CtrWidthDefault = 128;

  // One adder of this width serves the whole counter
  parameter int unsigned SliceSizeDefault = 16;

  ////////////////////
  // FSM encoding
  ////////////////////

  parameter int unsigned CtrStateWidth = 6;

  // Sparse codes, pairwise Hamming distance of at least 3
  // A single flipped bit never yields another legal state
  typedef enum logic [CtrStateWidth-1:0] {
    CTR_IDLE  = 6'b011101,
    CTR_INCR  = 6'b110010,
    CTR_ERROR = 6'b001011
  } aes_ctr_state_e;

  // Any other code of the state register is illegal
  // and sends the FSM into CTR_ERROR

endpackage : aes_ctr_pkg

//--- src/aes_ctr/aes_ctr_rail_guard.sv
/*
 * AES CTR increment rail guard
 * Checks the two-rail increment command and turns it into a
 * one-rail request, flagging broken rail pairs
 */
module aes_ctr_rail_guard (
  input  logic clk_i,
  input  logic rst_ni,

  // Two-rail command, true and inverted
  input  logic incr_i,
  input  logic incr_n_i,

  // Accepted load in the same cycle
  input  logic load_i,

  output logic incr_o,
  output logic incr_err_o
);

  logic rail_err;
  logic rail_err_q;

  // Rails must differ in every cycle
  assign rail_err = ~(incr_i ^ incr_n_i);

  // Sticky copy so a one-cycle glitch stays visible
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rail_err_q <= 1'b0;
    end else if (rail_err) begin
      rail_err_q <= 1'b1;
    end
  end

  // Current cycle reported at once, history from the flag
  assign incr_err_o = rail_err | rail_err_q;

  // Valid asserted pair only
  // A load in the same cycle drops the increment
  assign incr_o = incr_i & ~incr_n_i & ~load_i;

endmodule : aes_ctr_rail_guard

//--- src/aes_ctr/aes_ctr_fsm.sv
/*
 * AES CTR increment controller
 * Adds one to the counter a slice per cycle, lowest slice first,
 * carrying into the next slice; any error ends in a terminal state
 */
module aes_ctr_fsm #(
  parameter int unsigned SliceSize = aes_ctr_pkg::SliceSizeDefault,
  parameter int unsigned NumSlices =
      aes_ctr_pkg::CtrWidthDefault / aes_ctr_pkg::SliceSizeDefault,
  localparam int unsigned IdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Increment request and error sources
  input  logic                 incr_i,
  input  logic                 incr_err_i,
  input  logic                 ext_err_i,
  output logic                 ready_o,
  output logic                 alert_o,

  // Slice access to the counter register
  output logic [IdxWidth-1:0]  slice_idx_o,
  input  logic [SliceSize-1:0] slice_i,
  output logic [SliceSize-1:0] slice_o,
  output logic                 slice_we_o
);
  import aes_ctr_pkg::*;

  localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumSlices - 1);

  aes_ctr_state_e      state_d, state_q;
  logic [IdxWidth-1:0] slice_idx_d, slice_idx_q;
  logic                carry_d, carry_q;

  // One bit wider than a slice to keep the true carry-out
  logic [SliceSize:0]  sum;

  ////////////////////
  // Slice adder
  ////////////////////

  assign sum     = {1'b0, slice_i} + {{SliceSize{1'b0}}, carry_q};
  assign slice_o = sum[SliceSize-1:0];

  ////////////////////
  // Control
  ////////////////////

  always_comb begin
    // Defaults hold everything
    ready_o     = 1'b0;
    alert_o     = 1'b0;
    slice_we_o  = 1'b0;
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    unique case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Plus one enters as carry into slice 0
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        slice_we_o = 1'b1;
        // Carry-out of this slice feeds the next one
        carry_d    = sum[SliceSize];
        if (slice_idx_q == LastIdx) begin
          slice_idx_d = '0;
          state_d     = CTR_IDLE;
        end else begin
          slice_idx_d = slice_idx_q + IdxWidth'(1);
        end
      end

      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end

      default: begin
        // Illegal code, possibly a fault on the state flops
        alert_o = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Either error source overrides every transition
    if (incr_err_i || ext_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  assign slice_idx_o = slice_idx_q;

endmodule : aes_ctr_fsm

//--- src/aes_ctr/aes_ctr_reg.sv
/*
 * AES CTR counter register
 * Holds the counter as a row of slices, loads it in parallel and
 * gives the FSM read and write access to one slice at a time
 */
module aes_ctr_reg #(
  parameter int unsigned CtrWidth  = aes_ctr_pkg::CtrWidthDefault,
  parameter int unsigned SliceSize = aes_ctr_pkg::SliceSizeDefault,
  localparam int unsigned NumSlices = CtrWidth / SliceSize,
  localparam int unsigned IdxWidth  = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Parallel load
  input  logic                 load_i,
  input  logic [CtrWidth-1:0]  load_value_i,

  // Slice port towards the FSM
  input  logic [IdxWidth-1:0]  slice_idx_i,
  input  logic [SliceSize-1:0] slice_i,
  input  logic                 slice_we_i,
  output logic [SliceSize-1:0] slice_o,

  // Full counter value
  output logic [CtrWidth-1:0]  ctr_o
);

  // Slice 0 holds the least significant bits
  logic [NumSlices-1:0][SliceSize-1:0] ctr_d, ctr_q;

  ////////////////////
  // Next value
  ////////////////////

  always_comb begin
    ctr_d = ctr_q;
    if (load_i) begin
      // Load wins over a slice write
      ctr_d = load_value_i;
    end else if (slice_we_i) begin
      ctr_d[slice_idx_i] = slice_i;
    end
  end

  // Counter comes out of reset as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_d;
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  // Slice under the index, no register stage
  assign slice_o = ctr_q[slice_idx_i];

  assign ctr_o = ctr_q;

endmodule : aes_ctr_reg

//--- src/aes_ctr_top.sv
/*
 * AES CTR counter block
 * Rail guard, slice-serial increment FSM and counter register
 */
module aes_ctr_top #(
  parameter int unsigned CtrWidth  = aes_ctr_pkg::CtrWidthDefault,
  parameter int unsigned SliceSize = aes_ctr_pkg::SliceSizeDefault
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                load_i,
  input  logic [CtrWidth-1:0] load_value_i,
  input  logic                incr_i,
  input  logic                incr_n_i,
  input  logic                ext_err_i,

  output logic [CtrWidth-1:0] ctr_o,
  output logic                ready_o,
  output logic                alert_o
);

  // Must come out as a power of two
  localparam int unsigned NumSlices = CtrWidth / SliceSize;
  localparam int unsigned IdxWidth  = (NumSlices > 1) ? $clog2(NumSlices) : 1;

  logic                 load_gated;
  logic                 incr;
  logic                 incr_err;
  logic [IdxWidth-1:0]  slice_idx;
  logic [SliceSize-1:0] slice_wdata;
  logic [SliceSize-1:0] slice_rdata;
  logic                 slice_we;

  // Loads only count while idle
  assign load_gated = load_i & ready_o;

  aes_ctr_rail_guard u_guard (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .incr_i     (incr_i),
    .incr_n_i   (incr_n_i),
    .load_i     (load_gated),
    .incr_o     (incr),
    .incr_err_o (incr_err)
  );

  aes_ctr_fsm #(
    .SliceSize (SliceSize),
    .NumSlices (NumSlices)
  ) u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .incr_i      (incr),
    .incr_err_i  (incr_err),
    .ext_err_i   (ext_err_i),
    .ready_o     (ready_o),
    .alert_o     (alert_o),
    .slice_idx_o (slice_idx),
    .slice_i     (slice_rdata),
    .slice_o     (slice_wdata),
    .slice_we_o  (slice_we)
  );

  aes_ctr_reg #(
    .CtrWidth  (CtrWidth),
    .SliceSize (SliceSize)
  ) u_reg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (load_gated),
    .load_value_i (load_value_i),
    .slice_idx_i  (slice_idx),
    .slice_i      (slice_wdata),
    .slice_we_i   (slice_we),
    .slice_o      (slice_rdata),
    .ctr_o        (ctr_o)
  );

endmodule : aes_ctr_top

//--- verif/aes_ctr_props.sv
/*
 * AES CTR counter assertions
 * Alert, ready and slice write rules of the counter block
 */
module aes_ctr_props #(
  parameter int unsigned NumSlices =
      aes_ctr_pkg::CtrWidthDefault / aes_ctr_pkg::SliceSizeDefault
) (
  input logic clk_i,
  input logic rst_ni,
  input logic ready_i,
  input logic alert_i,
  input logic slice_we_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Error state never reports ready
  alert_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alert_i && ready_i))
    else $error("alert_o and ready_o high together");

  // Only reset clears the alert
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_i |=> alert_i)
    else $error("alert_o dropped without reset");

  // Idle means no slice write
  no_write_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_i |-> !slice_we_i)
    else $error("slice write while idle");

  // Full run of writes, cut short only by an error
  write_run_len: assert property (@(posedge clk_i) disable iff (!rst_ni || alert_i)
    $rose(slice_we_i) |-> slice_we_i [*NumSlices] ##1 !slice_we_i)
    else $error("increment did not take the expected number of slice writes");

endmodule : aes_ctr_props

bind aes_ctr_top aes_ctr_props #(
  .NumSlices (NumSlices)
) u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ready_i    (ready_o),
  .alert_i    (alert_o),
  .slice_we_i (slice_we)
);

//--- verif/aes_ctr_tb.sv
/*
 * AES CTR counter testbench
 * Random loads and increments checked against a reference counter,
 * plus rail and external error handling
 */
module aes_ctr_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import aes_ctr_pkg::*;

  localparam int unsigned CtrWidth     = CtrWidthDefault;
  localparam int unsigned SliceSize    = SliceSizeDefault;
  localparam int unsigned NumSlices    = CtrWidth / SliceSize;
  localparam int unsigned ReadyTimeout = 64;

  logic                clk;
  logic                rst_n;
  logic                load;
  logic [CtrWidth-1:0] load_value;
  logic                incr;
  logic                incr_n;
  logic                ext_err;
  logic [CtrWidth-1:0] ctr;
  logic                ready;
  logic                alert;

  // Reference counter
  logic [CtrWidth-1:0] model_ctr;

  int unsigned err_count;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned test_err_start;

  aes_ctr_top dut0 (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .load_i       (load),
    .load_value_i (load_value),
    .incr_i       (incr),
    .incr_n_i     (incr_n),
    .ext_err_i    (ext_err),
    .ctr_o        (ctr),
    .ready_o      (ready),
    .alert_o      (alert)
  );

  // 4 ns period
  always #2 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_val(input string name, input logic [CtrWidth-1:0] actual,
                           input logic [CtrWidth-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
      err_count++;
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count == test_err_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_count, name,
               err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  function automatic logic [CtrWidth-1:0] rand_ctr();
    logic [CtrWidth-1:0] val;
    for (int i = 0; i < CtrWidth / 32; i++) begin
      val[i*32 +: 32] = $urandom;
    end
    return val;
  endfunction

  // Ones in the lowest n slices
  function automatic logic [CtrWidth-1:0] low_mask(input int unsigned n);
    return (({{(CtrWidth-1){1'b0}}, 1'b1}) << (SliceSize * n)) - 1'b1;
  endfunction

  // Reset held for 10 cycles, rails back to idle
  task automatic apply_reset();
    @(posedge clk);
    rst_n   <= 1'b0;
    load    <= 1'b0;
    incr    <= 1'b0;
    incr_n  <= 1'b1;
    ext_err <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    model_ctr = '0;
  endtask

  // One-cycle load pulse, sampled after the accepting edge
  task automatic do_load(input logic [CtrWidth-1:0] value);
    @(posedge clk);
    load       <= 1'b1;
    load_value <= value;
    @(posedge clk);
    load <= 1'b0;
    @(negedge clk);
  endtask

  // Cycles counted from the edge that presents the request
  task automatic wait_ready(inout int unsigned cycles);
    @(negedge clk);
    while (!ready && cycles < ReadyTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      $display("ERROR at %0t: ready_o did not return within %0d cycles", $time, ReadyTimeout);
      err_count++;
    end
  endtask

  task automatic run_incr(output int unsigned cycles);
    @(posedge clk);
    incr   <= 1'b1;
    incr_n <= 1'b0;
    @(posedge clk);
    incr   <= 1'b0;
    incr_n <= 1'b1;
    cycles = 1;
    wait_ready(cycles);
  endtask

  // Increment with the expected result and latency
  task automatic incr_and_check();
    int unsigned cycles;
    run_incr(cycles);
    model_ctr = model_ctr + 1'b1;
    check_val("ctr_o", ctr, model_ctr);
    check_val("ready_o latency", cycles, NumSlices + 1);
  endtask

  // Both rails at the same level while idle
  task automatic rail_error(input logic level);
    logic [CtrWidth-1:0] val;
    @(posedge clk);
    incr   <= level;
    incr_n <= level;
    @(posedge clk);
    incr   <= 1'b0;
    incr_n <= 1'b1;
    @(negedge clk);
    repeat (5) begin
      check_val("alert_o", alert, 1'b1);
      check_val("ready_o", ready, 1'b0);
      @(negedge clk);
    end
    // Load must bounce off the error state
    val = rand_ctr();
    do_load(val);
    check_val("ctr_o", ctr, model_ctr);
    check_val("alert_o", alert, 1'b1);
    apply_reset();
    check_val("ready_o", ready, 1'b1);
    check_val("alert_o", alert, 1'b0);
    check_val("ctr_o", ctr, '0);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [CtrWidth-1:0] val;
    logic [CtrWidth-1:0] expected;
    int unsigned         cycles;
    int unsigned         k;

    void'($urandom(32'hc42e_4e8d));
    clk        = 1'b0;
    rst_n      = 1'b0;
    load       = 1'b0;
    load_value = '0;
    incr       = 1'b0;
    incr_n     = 1'b1;
    ext_err    = 1'b0;
    model_ctr  = '0;
    err_count      = 0;
    check_count    = 0;
    test_count     = 0;
    test_err_start = 0;

    apply_reset();
    check_val("ready_o", ready, 1'b1);
    check_val("alert_o", alert, 1'b0);
    check_val("ctr_o", ctr, '0);
    end_test("reset values");

    for (int i = 0; i < 6; i++) begin
      val = rand_ctr();
      do_load(val);
      model_ctr = val;
      check_val("ctr_o", ctr, model_ctr);
    end
    end_test("random loads");

    // Plain random, low slices of ones, and all ones
    for (int i = 0; i < 12; i++) begin
      val = rand_ctr();
      if (i == 0) begin
        val = '1;
      end else if (i % 3 == 1) begin
        val = val | low_mask($urandom_range(1, NumSlices - 1));
      end
      do_load(val);
      model_ctr = val;
      incr_and_check();
    end
    // Back to back without reload
    incr_and_check();
    incr_and_check();
    end_test("increments");

    // Loads and increment pulses while busy
    @(posedge clk);
    incr   <= 1'b1;
    incr_n <= 1'b0;
    @(posedge clk);
    incr   <= 1'b0;
    incr_n <= 1'b1;
    @(posedge clk);
    load       <= 1'b1;
    load_value <= rand_ctr();
    incr       <= 1'b1;
    incr_n     <= 1'b0;
    repeat (3) @(posedge clk);
    load   <= 1'b0;
    incr   <= 1'b0;
    incr_n <= 1'b1;
    cycles = 5;
    wait_ready(cycles);
    model_ctr = model_ctr + 1'b1;
    check_val("ctr_o", ctr, model_ctr);
    check_val("ready_o latency", cycles, NumSlices + 1);
    end_test("busy requests ignored");

    rail_error(1'b1);
    end_test("rails both high");
    rail_error(1'b0);
    end_test("rails both low");

    // External error after k slices were written
    // Ones below the top slice, so every slice write changes a value
    val = rand_ctr() | low_mask(NumSlices - 1);
    do_load(val);
    model_ctr = val;
    k = $urandom_range(1, NumSlices - 1);
    @(posedge clk);
    incr   <= 1'b1;
    incr_n <= 1'b0;
    @(posedge clk);
    incr   <= 1'b0;
    incr_n <= 1'b1;
    repeat (k - 1) @(posedge clk);
    ext_err <= 1'b1;
    @(posedge clk);
    ext_err <= 1'b0;
    @(negedge clk);
    expected = ((model_ctr + 1'b1) & low_mask(k)) | (model_ctr & ~low_mask(k));
    repeat (6) begin
      check_val("alert_o", alert, 1'b1);
      check_val("ready_o", ready, 1'b0);
      check_val("ctr_o", ctr, expected);
      @(negedge clk);
    end
    apply_reset();
    check_val("alert_o", alert, 1'b0);
    check_val("ctr_o", ctr, '0);
    end_test("external error");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : aes_ctr_tb

//--- verilog.f
common/aes_ctr_pkg.sv
src/aes_ctr/aes_ctr_rail_guard.sv
src/aes_ctr/aes_ctr_fsm.sv
src/aes_ctr/aes_ctr_reg.sv
src/aes_ctr_top.sv
verif/aes_ctr_props.sv
verif/aes_ctr_tb.sv

//--- Bender.yml
package:
  name: aes_ctr

sources:
  # Shared package
  - files:
      - common/aes_ctr_pkg.sv

  # Counter block RTL
  - files:
      - src/aes_ctr/aes_ctr_rail_guard.sv
      - src/aes_ctr/aes_ctr_fsm.sv
      - src/aes_ctr/aes_ctr_reg.sv
      - src/aes_ctr_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verif/aes_ctr_props.sv
      - verif/aes_ctr_tb.sv
